//--- exu_top.f
exu_pkg.sv
exu_alu.sv
exu_branch.sv
exu_csr.sv
exu_lsu.sv
exu_core.sv
exu_dmem.sv
exu_top.sv
tb_exu_top.sv

//--- Makefile
SRCS := $(shell grep -v '^+' exu_top.f)

obj_dir/Vtb_exu_top: exu_top.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_exu_top -f exu_top.f

run: obj_dir/Vtb_exu_top exu_tests.txt
	@out=$$(./obj_dir/Vtb_exu_top 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- exu_tests.txt
# issue: cls alu_op br_cond rd src1 src2 imm pc csr_addr
# expect: rd rd_wen rd_data redirect npc bus_err, every field in hex
0 0 0 01 5 7 0 100 000  01 1 c 0 104 0
0 1 0 02 3 5 0 104 000  02 1 fffffffffffffffe 0 108 0
0 2 0 00 f0f0 ff00 0 108 000  00 0 f000 0 10c 0
0 3 0 04 f0f0 0f0f 0 10c 000  04 1 ffff 0 110 0
0 4 0 05 ff00 0ff0 0 110 000  05 1 f0f0 0 114 0
0 5 0 06 1 43 0 114 000  06 1 8 0 118 0
0 6 0 07 8000000000000000 3f 0 118 000  07 1 1 0 11c 0
0 7 0 08 8000000000000000 4 0 11c 000  08 1 f800000000000000 0 120 0
0 8 0 09 ffffffffffffffff 1 0 120 000  09 1 1 0 124 0
0 9 0 0a ffffffffffffffff 1 0 124 000  0a 1 0 0 128 0
3 0 0 00 5 5 40 140 000  00 0 0 1 180 0
3 0 0 00 5 6 40 144 000  00 0 0 0 148 0
3 0 1 00 5 6 40 148 000  00 0 0 1 188 0
3 0 1 00 5 5 40 14c 000  00 0 0 0 150 0
3 0 2 00 ffffffffffffffff 1 40 150 000  00 0 0 1 190 0
3 0 2 00 1 ffffffffffffffff 40 154 000  00 0 0 0 158 0
3 0 3 00 1 ffffffffffffffff 40 158 000  00 0 0 1 198 0
3 0 3 00 ffffffffffffffff 1 40 15c 000  00 0 0 0 160 0
3 0 4 00 1 ffffffffffffffff 40 160 000  00 0 0 1 1a0 0
3 0 4 00 ffffffffffffffff 1 40 164 000  00 0 0 0 168 0
3 0 5 00 ffffffffffffffff 1 40 168 000  00 0 0 1 1a8 0
3 0 5 00 1 ffffffffffffffff 40 16c 000  00 0 0 0 170 0
4 0 0 01 0 0 80 200 000  01 1 204 1 280 0
5 0 0 02 1001 0 10 204 000  02 1 208 1 1010 0
2 0 0 00 100 1122334455667788 8 208 000  00 0 0 0 20c 0
1 0 0 0b 100 0 8 20c 000  0b 1 1122334455667788 0 210 0
1 0 0 0c 1000 0 0 210 000  0c 1 0 0 214 1
6 0 0 01 88 0 0 214 300  01 1 0 0 218 0
7 0 0 02 1 0 0 218 300  02 1 88 0 21c 0
8 0 0 03 80 0 0 21c 300  03 1 89 0 220 0
7 0 0 04 0 0 0 220 300  04 1 9 0 224 0
6 0 0 05 800 0 0 224 305  05 1 0 0 228 0
9 0 0 00 0 0 0 300 000  00 0 0 1 800 0
7 0 0 06 0 0 0 800 341  06 1 300 0 804 0
7 0 0 07 0 0 0 804 342  07 1 b 0 808 0
a 0 0 00 0 0 0 808 000  00 0 0 1 300 0
7 0 0 08 0 0 0 300 300  08 1 89 0 304 0

//--- tb_exu_top.sv
`timescale 1ns/10ps

module tb_exu_top import exu_pkg::*; ();

  localparam int clk_period      = 4;
  localparam int reset_cycles    = 10;
  localparam int cycles_per_test = 40;

  logic        clk;
  logic        rst;
  logic        in_valid;
  logic        in_ready;
  exu_issue_t  issue;
  logic        out_valid;
  logic        out_ready;
  exu_result_t result;

  // vectors from the data file in issue order
  exu_issue_t  issue_vec[$];
  exu_result_t expect_vec[$];
  logic [31:0] lfsr;
  logic        loaded;

  exu_top u_exu_top (
    .clk        (clk),
    .rst        (rst),
    .in_valid_i (in_valid),
    .in_ready_o (in_ready),
    .issue_i    (issue),
    .out_valid_o(out_valid),
    .out_ready_i(out_ready),
    .result_o   (result)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic stop_with_failure();
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  // fibonacci lfsr with taps 32 22 2 1
  // one step per drawn bit
  function automatic logic draw_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  task automatic check_field(input string name, input int idx,
                             input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("ERR %s test %0d got 0x%h exp 0x%h", name, idx, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic compare_result(input int idx, input exu_result_t got);
    exu_result_t exp;
    exp = expect_vec[idx];
    check_field("result_o.rd", idx, 64'(got.rd), 64'(exp.rd));
    check_field("result_o.rd_wen", idx, 64'(got.rd_wen), 64'(exp.rd_wen));
    check_field("result_o.rd_data", idx, got.rd_data, exp.rd_data);
    check_field("result_o.redirect", idx, 64'(got.redirect), 64'(exp.redirect));
    check_field("result_o.npc", idx, got.npc, exp.npc);
    check_field("result_o.bus_err", idx, 64'(got.bus_err), 64'(exp.bus_err));
  endtask

  // skips comment and empty lines
  // nine issue fields then six result fields
  task automatic load_tests();
    int          fd;
    int          n;
    string       line;
    logic [63:0] f [15];
    exu_issue_t  iss;
    exu_result_t res;
    fd = $fopen("exu_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open exu_tests.txt");
      stop_with_failure();
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                      f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
          if (n != 15) begin
            $display("malformed line in exu_tests.txt: %s", line);
            stop_with_failure();
          end else begin
            iss.cls      = exu_class_e'(f[0][3:0]);
            iss.alu_op   = alu_op_e'(f[1][3:0]);
            iss.br_cond  = br_cond_e'(f[2][2:0]);
            iss.rd       = f[3][4:0];
            iss.src1     = f[4];
            iss.src2     = f[5];
            iss.imm      = f[6];
            iss.pc       = f[7];
            iss.csr_addr = f[8][csr_addr_w-1:0];
            res.rd       = f[9][4:0];
            res.rd_wen   = f[10][0];
            res.rd_data  = f[11];
            res.redirect = f[12][0];
            res.npc      = f[13];
            res.bus_err  = f[14][0];
            issue_vec.push_back(iss);
            expect_vec.push_back(res);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // budget scales with the number of vectors
  initial begin
    wait (loaded);
    #((reset_cycles + cycles_per_test * issue_vec.size()) * clk_period);
    $display("timeout, the stage stopped returning results");
    stop_with_failure();
  end

  initial begin
    int          sent;
    int          got;
    logic        valid_bit;
    logic        ready_bit;
    logic        holding;
    exu_result_t held;

    rst       <= 1'b1;
    in_valid  <= 1'b0;
    out_ready <= 1'b0;
    issue     <= '0;
    lfsr      = 32'he277_4cfc;
    loaded    = 1'b0;
    load_tests();
    loaded    = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;

    sent    = 0;
    got     = 0;
    holding = 1'b0;
    while (got < expect_vec.size()) begin
      @(posedge clk);
      valid_bit = draw_bit();
      ready_bit = draw_bit();
      // values seen here are the ones the dut sampled on this edge
      if (in_valid && in_ready) sent++;
      if (holding) begin
        assert (out_valid) else begin
          $display("out_valid_o dropped before its result transferred");
          stop_with_failure();
        end
        assert (result === held) else begin
          $display("ERR result_o changed while held got 0x%h exp 0x%h", result, held);
          stop_with_failure();
        end
      end
      if (out_valid && out_ready) begin
        compare_result(got, result);
        got++;
        holding = 1'b0;
      end else begin
        holding = out_valid;
        held    = result;
      end
      // a stalled issue keeps valid and payload
      if (!(in_valid && !in_ready)) begin
        if (sent < issue_vec.size() && valid_bit) begin
          in_valid <= 1'b1;
          issue    <= issue_vec[sent];
        end else begin
          in_valid <= 1'b0;
        end
      end
      out_ready <= ready_bit;
    end

    // nothing may follow the last result
    in_valid  <= 1'b0;
    out_ready <= 1'b1;
    repeat (8) begin
      @(posedge clk);
      assert (!out_valid) else begin
        $display("out_valid_o rose again after the last expected result");
        stop_with_failure();
      end
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- exu_top.sv
`timescale 1ns/10ps

module exu_top import exu_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  input  exu_issue_t  issue_i,
  output logic        out_valid_o,
  input  logic        out_ready_i,
  output exu_result_t result_o
);

  // apb between the stage and its data memory
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;

  exu_core u_core (
    .clk        (clk),
    .rst        (rst),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .issue_i    (issue_i),
    .out_valid_o(out_valid_o),
    .out_ready_i(out_ready_i),
    .result_o   (result_o),
    .apb_o      (apb_req),
    .apb_i      (apb_rsp)
  );

  // one wait state per access
  exu_dmem u_dmem (
    .clk  (clk),
    .rst  (rst),
    .apb_i(apb_req),
    .apb_o(apb_rsp)
  );

endmodule

//--- exu_dmem.sv
`timescale 1ns/10ps

module exu_dmem import exu_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  apb_req_t apb_i,
  output apb_rsp_t apb_o
);

  logic [xlen-1:0]       mem_q [dmem_words];
  logic [dmem_idx_w-1:0] idx;
  logic                  in_range;
  logic                  access;
  // first access cycle done, ready on the next
  logic                  wait_q;
  logic                  complete;

  // doubleword index, byte offset ignored
  assign idx      = apb_i.paddr[dmem_off_w +: dmem_idx_w];
  assign in_range = (apb_i.paddr[xlen-1:dmem_off_w+dmem_idx_w] == '0);
  assign access   = apb_i.psel && apb_i.penable;
  assign complete = access && wait_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      wait_q <= 1'b0;
      for (int i = 0; i < dmem_words; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      wait_q <= access && !wait_q;
      // out-of-range writes dropped
      if (complete && apb_i.pwrite && in_range) begin
        mem_q[idx] <= apb_i.pwdata;
      end
    end
  end

  assign apb_o.pready  = complete;
  assign apb_o.pslverr = complete && !in_range;
  assign apb_o.prdata  = in_range ? mem_q[idx] : '0;

endmodule

//--- exu_core.sv
`timescale 1ns/10ps

module exu_core import exu_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  input  exu_issue_t  issue_i,
  output logic        out_valid_o,
  input  logic        out_ready_i,
  output exu_result_t result_o,
  output apb_req_t    apb_o,
  input  apb_rsp_t    apb_i
);

  core_state_e     state_q;
  exu_issue_t      iss_q;
  logic            in_fire;
  logic            out_fire;
  logic            in_is_mem;
  logic            is_mem;
  logic            is_csr;
  logic            writes_rd;
  logic [xlen-1:0] alu_a;
  logic [xlen-1:0] alu_b;
  alu_op_e         alu_op;
  logic [xlen-1:0] alu_res;
  logic            br_redirect;
  logic [xlen-1:0] br_npc;
  logic [xlen-1:0] csr_rdata;
  logic [xlen-1:0] csr_wdata;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;
  logic            lsu_done;
  logic [xlen-1:0] lsu_rdata;
  logic            lsu_err;

  // accept when empty or when the held result leaves now
  assign out_valid_o = (state_q == st_full);
  assign out_fire    = out_valid_o && out_ready_i;
  assign in_ready_o  = (state_q == st_empty) || out_fire;
  assign in_fire     = in_valid_i && in_ready_o;
  assign in_is_mem   = (issue_i.cls == cls_load) || (issue_i.cls == cls_store);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_empty;
    end else if (in_fire) begin
      state_q <= in_is_mem ? st_mem : st_full;
    end else if (out_fire) begin
      state_q <= st_empty;
    end else if ((state_q == st_mem) && lsu_done) begin
      state_q <= st_full;
    end
  end

  // instruction register, held until the result transfers
  always_ff @(posedge clk) begin
    if (in_fire) iss_q <= issue_i;
  end

  assign is_mem = (iss_q.cls == cls_load) || (iss_q.cls == cls_store);
  assign is_csr = (iss_q.cls == cls_csrrw) || (iss_q.cls == cls_csrrs) ||
                  (iss_q.cls == cls_csrrc);
  assign writes_rd = is_csr || (iss_q.cls == cls_alu) || (iss_q.cls == cls_load) ||
                     (iss_q.cls == cls_jal) || (iss_q.cls == cls_jalr);

  // alu operands per class
  always_comb begin
    alu_a  = iss_q.src1;
    alu_b  = iss_q.src2;
    alu_op = alu_add;
    case (iss_q.cls)
      cls_alu: alu_op = iss_q.alu_op;
      // effective address
      cls_load, cls_store: alu_b = iss_q.imm;
      cls_branch: begin
        case (iss_q.br_cond)
          br_eq, br_ne: alu_op = alu_sub;
          br_lt, br_ge: alu_op = alu_slt;
          default:      alu_op = alu_sltu;
        endcase
      end
      // link address pc + 4
      cls_jal, cls_jalr: begin
        alu_a = iss_q.pc;
        alu_b = 64'd4;
      end
      default: ;
    endcase
  end

  exu_alu u_alu (.a_i(alu_a), .b_i(alu_b), .op_i(alu_op), .res_o(alu_res));

  exu_branch u_branch (
    .issue_i(iss_q), .alu_res_i(alu_res), .mtvec_i(mtvec), .mepc_i(mepc),
    .redirect_o(br_redirect), .npc_o(br_npc)
  );

  // read-modify-write value, csr*i already has its imm in src1
  always_comb begin
    case (iss_q.cls)
      cls_csrrs: csr_wdata = csr_rdata | iss_q.src1;
      cls_csrrc: csr_wdata = csr_rdata & ~iss_q.src1;
      default:   csr_wdata = iss_q.src1;
    endcase
  end

  // csr side effects commit on the outgoing transfer
  exu_csr u_csr (
    .clk(clk), .rst(rst), .raddr_i(iss_q.csr_addr), .rdata_o(csr_rdata),
    .wen_i(out_fire && is_csr), .waddr_i(iss_q.csr_addr), .wdata_i(csr_wdata),
    .ecall_i(out_fire && (iss_q.cls == cls_ecall)),
    .mret_i(out_fire && (iss_q.cls == cls_mret)),
    .epc_i(iss_q.pc), .mtvec_o(mtvec), .mepc_o(mepc)
  );

  // apb transfer starts with the accepting edge
  exu_lsu u_lsu (
    .clk(clk), .rst(rst), .start_i(in_fire && in_is_mem),
    .store_i(issue_i.cls == cls_store), .addr_i(alu_res), .wdata_i(iss_q.src2),
    .apb_o(apb_o), .apb_i(apb_i), .done_o(lsu_done), .rdata_o(lsu_rdata),
    .err_o(lsu_err)
  );

  always_comb begin
    result_o.rd       = iss_q.rd;
    result_o.rd_wen   = writes_rd && (iss_q.rd != 5'd0);
    result_o.redirect = br_redirect;
    result_o.npc      = br_npc;
    result_o.bus_err  = is_mem && lsu_err;
    case (iss_q.cls)
      cls_alu, cls_jal, cls_jalr:  result_o.rd_data = alu_res;
      cls_load:                    result_o.rd_data = lsu_rdata;
      // old csr value
      cls_csrrw, cls_csrrs, cls_csrrc: result_o.rd_data = csr_rdata;
      default:                     result_o.rd_data = '0;
    endcase
  end

endmodule

//--- exu_lsu.sv
`timescale 1ns/10ps

module exu_lsu import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            start_i,
  input  logic            store_i,
  input  logic [xlen-1:0] addr_i,
  input  logic [xlen-1:0] wdata_i,
  output apb_req_t        apb_o,
  input  apb_rsp_t        apb_i,
  output logic            done_o,
  output logic [xlen-1:0] rdata_o,
  output logic            err_o
);

  lsu_state_e      state_q;
  logic            store_q;
  logic [xlen-1:0] rdata_q;
  logic            err_q;
  // access phase finishing this cycle
  logic            complete;

  assign complete = (state_q == lsu_access) && apb_i.pready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= lsu_idle;
      store_q <= 1'b0;
    end else begin
      case (state_q)
        lsu_idle: begin
          if (start_i) begin
            state_q <= lsu_setup;
            store_q <= store_i;
          end
        end
        // setup lasts one cycle
        lsu_setup: state_q <= lsu_access;
        lsu_access: begin
          if (apb_i.pready) state_q <= lsu_idle;
        end
        default: state_q <= lsu_idle;
      endcase
    end
  end

  // hold read data and error until the next transfer
  always_ff @(posedge clk) begin
    if (complete) begin
      rdata_q <= apb_i.prdata;
      err_q   <= apb_i.pslverr;
    end
  end

  // addr and data held stable by the core register
  assign apb_o.paddr   = addr_i;
  assign apb_o.pwdata  = wdata_i;
  assign apb_o.pwrite  = store_q;
  assign apb_o.psel    = (state_q != lsu_idle);
  assign apb_o.penable = (state_q == lsu_access);

  assign done_o  = complete;
  assign rdata_o = rdata_q;
  assign err_o   = err_q;

endmodule

//--- exu_csr.sv
`timescale 1ns/10ps

module exu_csr import exu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [csr_addr_w-1:0] raddr_i,
  output logic [xlen-1:0]       rdata_o,
  input  logic                  wen_i,
  input  logic [csr_addr_w-1:0] waddr_i,
  input  logic [xlen-1:0]       wdata_i,
  input  logic                  ecall_i,
  input  logic                  mret_i,
  input  logic [xlen-1:0]       epc_i,
  output logic [xlen-1:0]       mtvec_o,
  output logic [xlen-1:0]       mepc_o
);

  logic [xlen-1:0] mstatus_q;
  logic [xlen-1:0] mtvec_q;
  logic [xlen-1:0] mepc_q;
  logic [xlen-1:0] mcause_q;

  // read port, unknown csrs read as zero
  always_comb begin
    case (raddr_i)
      csr_mstatus: rdata_o = mstatus_q;
      csr_mtvec:   rdata_o = mtvec_q;
      csr_mepc:    rdata_o = mepc_q;
      csr_mcause:  rdata_o = mcause_q;
      default:     rdata_o = '0;
    endcase
  end

  // trap vector and return address for the branch unit
  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      // csrrw/s/c, writes to other addresses dropped
      if (wen_i) begin
        case (waddr_i)
          csr_mstatus: mstatus_q <= wdata_i;
          csr_mtvec:   mtvec_q   <= wdata_i;
          csr_mepc:    mepc_q    <= wdata_i;
          csr_mcause:  mcause_q  <= wdata_i;
          default:     ;
        endcase
      end
      // trap entry: save pc, cause, stack mie into mpie
      if (ecall_i) begin
        mepc_q                      <= epc_i;
        mcause_q                    <= cause_ecall_m;
        mstatus_q[mstatus_mpie_bit] <= mstatus_q[mstatus_mie_bit];
        mstatus_q[mstatus_mie_bit]  <= 1'b0;
      end
      // trap return: restore mie, mpie goes to one
      if (mret_i) begin
        mstatus_q[mstatus_mie_bit]  <= mstatus_q[mstatus_mpie_bit];
        mstatus_q[mstatus_mpie_bit] <= 1'b1;
      end
    end
  end

endmodule

//--- exu_branch.sv
`timescale 1ns/10ps

module exu_branch import exu_pkg::*; (
  input  exu_issue_t      issue_i,
  input  logic [xlen-1:0] alu_res_i,
  input  logic [xlen-1:0] mtvec_i,
  input  logic [xlen-1:0] mepc_i,
  output logic            redirect_o,
  output logic [xlen-1:0] npc_o
);

  logic [xlen-1:0] seq_pc;
  logic [xlen-1:0] jal_tgt;
  logic [xlen-1:0] jalr_tgt;
  logic            taken;

  // fall-through and jump targets
  assign seq_pc   = issue_i.pc + 64'd4;
  assign jal_tgt  = issue_i.pc + issue_i.imm;
  assign jalr_tgt = (issue_i.src1 + issue_i.imm) & ~64'd1;

  // alu ran sub for eq/ne, slt or sltu for the rest
  always_comb begin
    case (issue_i.br_cond)
      br_eq:   taken = (alu_res_i == '0);
      br_ne:   taken = (alu_res_i != '0);
      br_lt:   taken = alu_res_i[0];
      br_ge:   taken = !alu_res_i[0];
      br_ltu:  taken = alu_res_i[0];
      br_geu:  taken = !alu_res_i[0];
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    redirect_o = 1'b1;
    npc_o      = seq_pc;
    case (issue_i.cls)
      cls_branch: begin
        redirect_o = taken;
        npc_o      = taken ? jal_tgt : seq_pc;
      end
      cls_jal:   npc_o = jal_tgt;
      cls_jalr:  npc_o = jalr_tgt;
      // trap entry and return
      cls_ecall: npc_o = mtvec_i;
      cls_mret:  npc_o = mepc_i;
      default:   redirect_o = 1'b0;
    endcase
  end

endmodule

//--- exu_alu.sv
`timescale 1ns/10ps

module exu_alu import exu_pkg::*; (
  input  logic [xlen-1:0] a_i,
  input  logic [xlen-1:0] b_i,
  input  alu_op_e         op_i,
  output logic [xlen-1:0] res_o
);

  // rv64 shift amount, low six bits only
  logic [5:0] shamt;
  // compare outcomes, zero extended into the result
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b_i[5:0];
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      alu_add: begin
        res_o = a_i + b_i;
      end
      // also used for eq/ne branch compare
      alu_sub: begin
        res_o = a_i - b_i;
      end
      alu_and: begin
        res_o = a_i & b_i;
      end
      alu_or: begin
        res_o = a_i | b_i;
      end
      alu_xor: begin
        res_o = a_i ^ b_i;
      end
      alu_sll: begin
        res_o = a_i << shamt;
      end
      alu_srl: begin
        res_o = a_i >> shamt;
      end
      // arithmetic, sign bit fills from the top
      alu_sra: begin
        res_o = $signed(a_i) >>> shamt;
      end
      alu_slt: begin
        res_o = {{(xlen-1){1'b0}}, lt_signed};
      end
      alu_sltu: begin
        res_o = {{(xlen-1){1'b0}}, lt_unsigned};
      end
      default: begin
        res_o = '0;
      end
    endcase
  end

endmodule

//--- exu_pkg.sv
package exu_pkg;

  // datapath and csr widths
  localparam int xlen       = 64;
  localparam int csr_addr_w = 12;

  // machine csr addresses
  localparam logic [csr_addr_w-1:0] csr_mstatus = 12'h300;
  localparam logic [csr_addr_w-1:0] csr_mtvec   = 12'h305;
  localparam logic [csr_addr_w-1:0] csr_mepc    = 12'h341;
  localparam logic [csr_addr_w-1:0] csr_mcause  = 12'h342;

  // environment call from m-mode
  localparam logic [xlen-1:0] cause_ecall_m = 64'd11;

  // mstatus interrupt enable bits
  localparam int mstatus_mie_bit  = 3;
  localparam int mstatus_mpie_bit = 7;

  // data memory geometry, doubleword entries
  localparam int dmem_words = 256;
  localparam int dmem_idx_w = $clog2(dmem_words);
  // byte offset inside a doubleword
  localparam int dmem_off_w = 3;

  typedef enum logic [3:0] {
    cls_alu, cls_load, cls_store, cls_branch, cls_jal, cls_jalr,
    cls_csrrw, cls_csrrs, cls_csrrc, cls_ecall, cls_mret
  } exu_class_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu
  } alu_op_e;

  typedef enum logic [2:0] {
    br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu
  } br_cond_e;

  // sequencing fsm of the stage
  typedef enum logic [1:0] {st_empty, st_mem, st_full} core_state_e;

  // apb master phases
  typedef enum logic [1:0] {lsu_idle, lsu_setup, lsu_access} lsu_state_e;

  // decoded instruction from decode
  typedef struct packed {
    exu_class_e            cls;
    alu_op_e               alu_op;
    br_cond_e              br_cond;
    logic [4:0]            rd;
    logic [xlen-1:0]       src1;
    logic [xlen-1:0]       src2;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       pc;
    logic [csr_addr_w-1:0] csr_addr;
  } exu_issue_t;

  // write-back and redirect to the next stage
  typedef struct packed {
    logic [4:0]      rd;
    logic            rd_wen;
    logic [xlen-1:0] rd_data;
    logic            redirect;
    logic [xlen-1:0] npc;
    logic            bus_err;
  } exu_result_t;

  typedef struct packed {
    logic [xlen-1:0] paddr;
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [xlen-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [xlen-1:0] prdata;
    logic            pready;
    logic            pslverr;
  } apb_rsp_t;

endpackage
